//--- design/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

	// bus widths
	localparam int data_width = 32;
	localparam int addr_width = 5;

	// coprocessor register numbers
	localparam logic [addr_width-1:0] reg_count   = 5'd9;
	localparam logic [addr_width-1:0] reg_compare = 5'd11;
	localparam logic [addr_width-1:0] reg_status  = 5'd12;
	localparam logic [addr_width-1:0] reg_cause   = 5'd13;
	localparam logic [addr_width-1:0] reg_epc     = 5'd14;
	localparam logic [addr_width-1:0] reg_prid    = 5'd15;

	// exception codes, any nonzero exc input is an exception
	localparam logic [4:0] exc_none = 5'd0;
	localparam logic [4:0] exc_int  = 5'd0; // interrupt.

	// status fields
	localparam int sr_ie    = 0;  // global interrupt enable.
	localparam int sr_exl   = 1;  // exception level.
	localparam int sr_im_lo = 10;
	localparam int sr_im_hi = 15; // hardware interrupt mask.

	// cause fields
	localparam int cause_exc_lo = 2;
	localparam int cause_exc_hi = 6;
	localparam int cause_ip_lo  = 10;
	localparam int cause_ip_hi  = 15; // pending hardware interrupts.
	localparam int cause_bd     = 31; // taken in a branch delay slot.

	// processor id reported on reads of prid
	localparam logic [data_width-1:0] prid_default = 32'h0000_0220;

endpackage

`default_nettype wire

//--- design/cp0_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cp0_wb_if;
	import cp0_pkg::*;

	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [addr_width-1:0] adr;
	logic [data_width-1:0] dat_w; // master to slave.
	logic [data_width-1:0] dat_r; // slave to master.
	logic                  ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

`default_nettype wire

//--- design/cp0_wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_wb_arbiter (
	input logic clk,
	input logic rst,
	cp0_wb_if.slave  core_s,
	cp0_wb_if.slave  debug_s,
	cp0_wb_if.master bus_m
);
	import cp0_pkg::*;

	logic busy_q;  // a master owns the bus.
	logic owner_q; // 0 core, 1 debug.
	logic sel_dbg;
	logic req_cyc;

	// while idle the core wins, otherwise the owner keeps the bus
	always_comb begin
		if (busy_q) begin
			sel_dbg = owner_q;
		end else begin
			sel_dbg = ~core_s.cyc;
		end
	end

	assign req_cyc = sel_dbg ? debug_s.cyc : core_s.cyc;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
		end else if (!busy_q) begin
			if (core_s.cyc || debug_s.cyc) begin
				busy_q  <= 1'b1;
				owner_q <= sel_dbg; // lock the grant.
			end
		end else if (!req_cyc) begin
			busy_q <= 1'b0; // owner dropped cyc.
		end
	end

	// forward the selected request
	assign bus_m.cyc   = req_cyc;
	assign bus_m.stb   = sel_dbg ? debug_s.stb : core_s.stb;
	assign bus_m.we    = sel_dbg ? debug_s.we : core_s.we;
	assign bus_m.adr   = sel_dbg ? debug_s.adr : core_s.adr;
	assign bus_m.dat_w = sel_dbg ? debug_s.dat_w : core_s.dat_w;

	// only the owner sees the response
	assign core_s.ack    = bus_m.ack & ~sel_dbg;
	assign debug_s.ack   = bus_m.ack & sel_dbg;
	assign core_s.dat_r  = sel_dbg ? '0 : bus_m.dat_r;
	assign debug_s.dat_r = sel_dbg ? bus_m.dat_r : '0;

endmodule

`default_nettype wire

//--- design/cp0_reg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_reg_decoder (
	input logic clk,
	input logic rst,
	cp0_wb_if.slave  bus_s,
	cp0_wb_if.master status_m,
	cp0_wb_if.master timer_m
);
	import cp0_pkg::*;

	logic sel_status;
	logic sel_timer;
	logic sel_none;
	logic none_ack_q; // ack for unmapped registers.

	always_comb begin
		sel_status = (bus_s.adr == reg_status) || (bus_s.adr == reg_cause) ||
			(bus_s.adr == reg_epc) || (bus_s.adr == reg_prid);
		sel_timer  = (bus_s.adr == reg_count) || (bus_s.adr == reg_compare);
		sel_none   = ~sel_status & ~sel_timer;
	end

	assign status_m.cyc   = bus_s.cyc & sel_status;
	assign status_m.stb   = bus_s.stb & sel_status;
	assign status_m.we    = bus_s.we;
	assign status_m.adr   = bus_s.adr;
	assign status_m.dat_w = bus_s.dat_w;

	assign timer_m.cyc   = bus_s.cyc & sel_timer;
	assign timer_m.stb   = bus_s.stb & sel_timer;
	assign timer_m.we    = bus_s.we;
	assign timer_m.adr   = bus_s.adr;
	assign timer_m.dat_w = bus_s.dat_w;

	// same one cycle latency as the real slaves
	always_ff @(posedge clk) begin
		if (rst) begin
			none_ack_q <= 1'b0;
		end else begin
			none_ack_q <= bus_s.cyc & bus_s.stb & sel_none & ~none_ack_q;
		end
	end

	assign bus_s.ack   = status_m.ack | timer_m.ack | none_ack_q;
	assign bus_s.dat_r = status_m.ack ? status_m.dat_r :
		timer_m.ack ? timer_m.dat_r : '0; // unmapped reads zero.

endmodule

`default_nettype wire

//--- design/cp0_status.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_status #(
	parameter logic [cp0_pkg::data_width-1:0] prid_value = cp0_pkg::prid_default
) (
	input  logic                             clk,
	input  logic                             rst,
	cp0_wb_if.slave                          bus_s,
	input  logic [4:0]                       exc_i,
	input  logic [cp0_pkg::data_width-1:0]   curr_pc_i,
	input  logic                             in_bds_i,
	input  logic                             exit_isr_i,
	input  logic [5:0]                       hwirq_i,
	input  logic                             timer_irq_i,
	output logic [cp0_pkg::data_width-1:0]   epc_o,
	output logic                             have2handle_o
);
	import cp0_pkg::*;

	localparam int im_bits = sr_im_hi - sr_im_lo + 1;
	localparam int ip_bits = cause_ip_hi - cause_ip_lo + 1;
	localparam int ec_bits = cause_exc_hi - cause_exc_lo + 1;

	// status fields
	logic [im_bits-1:0] im_q;
	logic               exl_q;
	logic               ie_q;

	// cause fields
	logic [ec_bits-1:0] exc_code_q;
	logic [ip_bits-1:0] ip_q;
	logic               bd_q;

	logic [data_width-1:0] epc_q;
	logic [data_width-1:0] dat_r_q;
	logic                  ack_q;

	logic [ip_bits-1:0]    hwirq_m;
	logic                  have_irq;
	logic                  have_exc;
	logic                  acc;
	logic                  wr;
	logic [data_width-1:0] status_word;
	logic [data_width-1:0] cause_word;
	logic [data_width-1:0] rd_word;

	// timer rides on line 5
	assign hwirq_m = hwirq_i | {timer_irq_i, 5'b0};

	assign have_irq = (|(hwirq_m & im_q)) & ie_q & ~exl_q;
	assign have_exc = (exc_i != exc_none) & ~exl_q;
	assign have2handle_o = have_irq | have_exc;

	assign acc = bus_s.cyc & bus_s.stb & ~ack_q; // first stb cycle.
	assign wr  = acc & bus_s.we;

	always_comb begin
		status_word = '0;
		status_word[sr_im_hi:sr_im_lo] = im_q;
		status_word[sr_exl] = exl_q;
		status_word[sr_ie] = ie_q;

		cause_word = '0;
		cause_word[cause_exc_hi:cause_exc_lo] = exc_code_q;
		cause_word[cause_ip_hi:cause_ip_lo] = ip_q;
		cause_word[cause_bd] = bd_q;

		case (bus_s.adr)
			reg_status: rd_word = status_word;
			reg_cause:  rd_word = cause_word;
			reg_epc:    rd_word = epc_q;
			reg_prid:   rd_word = prid_value;
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			im_q       <= '0;
			exl_q      <= 1'b0;
			ie_q       <= 1'b0;
			exc_code_q <= '0;
			ip_q       <= '0;
			bd_q       <= 1'b0;
			epc_q      <= '0;
		end else begin
			if (have2handle_o) begin
				exl_q <= 1'b1;
				bd_q  <= in_bds_i;
				epc_q <= in_bds_i ? curr_pc_i - 32'd4 : curr_pc_i; // point at the branch.
				exc_code_q <= have_irq ? exc_int : exc_i; // interrupt wins.
			end else if (wr) begin
				case (bus_s.adr)
					reg_status: begin
						im_q  <= bus_s.dat_w[sr_im_hi:sr_im_lo];
						exl_q <= bus_s.dat_w[sr_exl];
						ie_q  <= bus_s.dat_w[sr_ie];
					end
					reg_epc: epc_q <= bus_s.dat_w;
					default: ; // cause and prid are read only.
				endcase
			end else if (exit_isr_i) begin
				exl_q <= 1'b0;
			end
			ip_q <= hwirq_m; // sampled every cycle.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= acc;
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			dat_r_q <= rd_word;
		end
	end

	assign bus_s.ack   = ack_q;
	assign bus_s.dat_r = dat_r_q;
	assign epc_o       = epc_q;

endmodule

`default_nettype wire

//--- design/cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer (
	input  logic clk,
	input  logic rst,
	cp0_wb_if.slave bus_s,
	output logic timer_irq_o
);
	import cp0_pkg::*;

	logic [data_width-1:0] count_q;
	logic [data_width-1:0] compare_q;
	logic                  pending_q;
	logic                  ack_q;
	logic [data_width-1:0] dat_r_q;
	logic                  acc;
	logic                  wr_count;
	logic                  wr_compare;

	assign acc        = bus_s.cyc & bus_s.stb & ~ack_q;
	assign wr_count   = acc & bus_s.we & (bus_s.adr == reg_count);
	assign wr_compare = acc & bus_s.we & (bus_s.adr == reg_compare);

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q   <= '0;
			compare_q <= '0;
			pending_q <= 1'b0;
		end else begin
			if (wr_count) begin
				count_q <= bus_s.dat_w;
			end else begin
				count_q <= count_q + 1; // free running.
			end

			if (wr_compare) begin
				compare_q <= bus_s.dat_w;
				pending_q <= 1'b0; // writing compare acknowledges the tick.
			end else if ((compare_q != '0) && (count_q == compare_q)) begin
				pending_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= acc;
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			dat_r_q <= (bus_s.adr == reg_compare) ? compare_q : count_q;
		end
	end

	assign bus_s.ack   = ack_q;
	assign bus_s.dat_r = dat_r_q;
	assign timer_irq_o = pending_q;

endmodule

`default_nettype wire

//--- design/cp0_top.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
	parameter logic [cp0_pkg::data_width-1:0] prid_value = cp0_pkg::prid_default
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             core_cyc_i,
	input  logic                             core_stb_i,
	input  logic                             core_we_i,
	input  logic [cp0_pkg::addr_width-1:0]   core_adr_i,
	input  logic [cp0_pkg::data_width-1:0]   core_dat_i,
	output logic [cp0_pkg::data_width-1:0]   core_dat_o,
	output logic                             core_ack_o,
	input  logic                             dbg_cyc_i,
	input  logic                             dbg_stb_i,
	input  logic                             dbg_we_i,
	input  logic [cp0_pkg::addr_width-1:0]   dbg_adr_i,
	input  logic [cp0_pkg::data_width-1:0]   dbg_dat_i,
	output logic [cp0_pkg::data_width-1:0]   dbg_dat_o,
	output logic                             dbg_ack_o,
	input  logic [4:0]                       exc_i,
	input  logic [cp0_pkg::data_width-1:0]   curr_pc_i,
	input  logic                             in_bds_i,
	input  logic                             exit_isr_i,
	input  logic [5:0]                       hwirq_i,
	output logic [cp0_pkg::data_width-1:0]   epc_o,
	output logic                             have2handle_o
);

	cp0_wb_if core_bus ();
	cp0_wb_if dbg_bus ();
	cp0_wb_if shared_bus (); // after arbitration.
	cp0_wb_if status_bus ();
	cp0_wb_if timer_bus ();

	logic timer_irq;

	assign core_bus.cyc   = core_cyc_i;
	assign core_bus.stb   = core_stb_i;
	assign core_bus.we    = core_we_i;
	assign core_bus.adr   = core_adr_i;
	assign core_bus.dat_w = core_dat_i;
	assign core_dat_o     = core_bus.dat_r;
	assign core_ack_o     = core_bus.ack;

	assign dbg_bus.cyc   = dbg_cyc_i;
	assign dbg_bus.stb   = dbg_stb_i;
	assign dbg_bus.we    = dbg_we_i;
	assign dbg_bus.adr   = dbg_adr_i;
	assign dbg_bus.dat_w = dbg_dat_i;
	assign dbg_dat_o     = dbg_bus.dat_r;
	assign dbg_ack_o     = dbg_bus.ack;

	cp0_wb_arbiter u_arbiter (
		.clk     (clk),
		.rst     (rst),
		.core_s  (core_bus.slave),
		.debug_s (dbg_bus.slave),
		.bus_m   (shared_bus.master)
	);

	cp0_reg_decoder u_decoder (
		.clk      (clk),
		.rst      (rst),
		.bus_s    (shared_bus.slave),
		.status_m (status_bus.master),
		.timer_m  (timer_bus.master)
	);

	cp0_status #(
		.prid_value (prid_value)
	) u_status (
		.clk           (clk),
		.rst           (rst),
		.bus_s         (status_bus.slave),
		.exc_i         (exc_i),
		.curr_pc_i     (curr_pc_i),
		.in_bds_i      (in_bds_i),
		.exit_isr_i    (exit_isr_i),
		.hwirq_i       (hwirq_i),
		.timer_irq_i   (timer_irq),
		.epc_o         (epc_o),
		.have2handle_o (have2handle_o)
	);

	cp0_timer u_timer (
		.clk         (clk),
		.rst         (rst),
		.bus_s       (timer_bus.slave),
		.timer_irq_o (timer_irq)
	);

endmodule

`default_nettype wire

//--- bench/cp0_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_assert (
	input logic clk,
	input logic rst,
	input logic core_stb_i,
	input logic core_ack_i,
	input logic dbg_stb_i,
	input logic dbg_ack_i,
	input logic have2handle_i,
	input logic exl_i
);

	// sampled on the falling edge, while the master still holds stb.
	core_ack_has_stb: assert property (@(negedge clk) disable iff (rst) core_ack_i |-> core_stb_i)
		else $error("core ack seen without core stb");

	dbg_ack_has_stb: assert property (@(negedge clk) disable iff (rst) dbg_ack_i |-> dbg_stb_i)
		else $error("debug ack seen without debug stb");

	acks_exclusive: assert property (@(negedge clk) disable iff (rst) !(core_ack_i && dbg_ack_i))
		else $error("core and debug ack high together");

	exl_after_entry: assert property (@(posedge clk) disable iff (rst) have2handle_i |=> exl_i)
		else $error("exl not set after have2handle");

endmodule

bind cp0_top cp0_assert u_assert (
	.clk           (clk),
	.rst           (rst),
	.core_stb_i    (core_stb_i),
	.core_ack_i    (core_ack_o),
	.dbg_stb_i     (dbg_stb_i),
	.dbg_ack_i     (dbg_ack_o),
	.have2handle_i (have2handle_o),
	.exl_i         (u_status.exl_q)
);

`default_nettype wire

//--- bench/cp0_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;
	import cp0_pkg::*;

	localparam logic [31:0] prid_tb = 32'h0001_9a05;
	localparam logic [31:0] status_mask = 32'h0000_fc03; // im, exl and ie.
	localparam int max_wait = 16; // cycles an access may wait for ack.
	localparam int access_count = 150;
	localparam int watchdog_ns = (access_count * (max_wait + 2) + 200) * 20;

	logic        clk = 1'b0;
	logic        rst;
	logic        core_cyc;
	logic        core_stb;
	logic        core_we;
	logic [4:0]  core_adr;
	logic [31:0] core_wdat;
	logic [31:0] core_rdat;
	logic        core_ack;
	logic        dbg_cyc;
	logic        dbg_stb;
	logic        dbg_we;
	logic [4:0]  dbg_adr;
	logic [31:0] dbg_wdat;
	logic [31:0] dbg_rdat;
	logic        dbg_ack;
	logic [4:0]  exc;
	logic [31:0] curr_pc;
	logic        in_bds;
	logic        exit_isr;
	logic [5:0]  hwirq;
	logic [31:0] epc;
	logic        have2handle;

	// software copy of the registers
	logic [31:0] status_m;
	logic [31:0] cause_m;
	logic [31:0] epc_m;
	logic [31:0] compare_m;
	logic [31:0] seed;

	logic [31:0] got_q[$];
	logic [31:0] exp_q[$];
	string       tag_q[$];
	int          errors;
	int          checks;
	int          tests;
	int          test_errors;

	cp0_top #(
		.prid_value (prid_tb)
	) DUT (
		.clk (clk), .rst (rst),
		.core_cyc_i (core_cyc), .core_stb_i (core_stb), .core_we_i (core_we),
		.core_adr_i (core_adr), .core_dat_i (core_wdat), .core_dat_o (core_rdat),
		.core_ack_o (core_ack),
		.dbg_cyc_i (dbg_cyc), .dbg_stb_i (dbg_stb), .dbg_we_i (dbg_we),
		.dbg_adr_i (dbg_adr), .dbg_dat_i (dbg_wdat), .dbg_dat_o (dbg_rdat),
		.dbg_ack_o (dbg_ack),
		.exc_i (exc), .curr_pc_i (curr_pc), .in_bds_i (in_bds), .exit_isr_i (exit_isr),
		.hwirq_i (hwirq), .epc_o (epc), .have2handle_o (have2handle)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] expected_read(input logic [4:0] adr);
		case (adr)
			reg_status:  return status_m;
			reg_cause:   return cause_m;
			reg_epc:     return epc_m;
			reg_prid:    return prid_tb;
			reg_compare: return compare_m;
			default:     return 32'h0; // unmapped.
		endcase
	endfunction

	function automatic void enter_model(input logic is_irq, input logic [4:0] code,
			input logic [31:0] pc, input logic bds);
		status_m[sr_exl] = 1'b1;
		cause_m[cause_bd] = bds;
		cause_m[cause_exc_hi:cause_exc_lo] = is_irq ? 5'd0 : code;
		epc_m = bds ? pc - 32'd4 : pc;
	endfunction

	// drains the pending checks once per cycle.
	always @(posedge clk) begin : compare_proc
		logic [31:0] got;
		logic [31:0] want;
		string       tag;
		while (got_q.size() != 0) begin
			got = got_q.pop_front();
			want = exp_q.pop_front();
			tag = tag_q.pop_front();
			checks++;
			if (got !== want) begin
				$display("ERR %0t: %s is %h, expected %h", $time, tag, got, want);
				errors++;
			end
		end
	end

	task automatic expect_value(input logic [31:0] got, input logic [31:0] want,
			input string tag);
		got_q.push_back(got);
		exp_q.push_back(want);
		tag_q.push_back(tag);
	endtask

	task automatic drive_port(input logic use_dbg, input logic active, input logic we,
			input logic [4:0] adr, input logic [31:0] data);
		if (use_dbg) begin
			dbg_cyc = active;
			dbg_stb = active;
			dbg_we = we;
			dbg_adr = adr;
			dbg_wdat = data;
		end else begin
			core_cyc = active;
			core_stb = active;
			core_we = we;
			core_adr = adr;
			core_wdat = data;
		end
	endtask

	task automatic bus_access(input logic use_dbg, input logic we, input logic [4:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int   waited;
		logic ack;
		waited = 0;
		ack = 1'b0;
		@(negedge clk);
		drive_port(use_dbg, 1'b1, we, adr, wdata);
		while (!ack && waited < max_wait) begin
			@(negedge clk);
			waited++;
			ack = use_dbg ? dbg_ack : core_ack;
		end
		rdata = use_dbg ? dbg_rdat : core_rdat;
		drive_port(use_dbg, 1'b0, 1'b0, 5'd0, 32'h0);
		if (!ack) begin
			$display("no ack for register %0d on the %s port", adr, use_dbg ? "debug" : "core");
			errors++;
		end
	endtask

	task automatic bus_write(input logic use_dbg, input logic [4:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(use_dbg, 1'b1, adr, data, unused);
	endtask

	task automatic bus_read(input logic use_dbg, input logic [4:0] adr, output logic [31:0] data);
		bus_access(use_dbg, 1'b0, adr, 32'h0, data);
	endtask

	task automatic read_check(input logic use_dbg, input logic [4:0] adr, input string tag);
		logic [31:0] data;
		bus_read(use_dbg, adr, data);
		expect_value(data, expected_read(adr), tag);
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		#1;
		tests++;
		if (errors == test_errors) begin
			$display("test %0d, %s: passed", tests, name);
		end else begin
			$display("test %0d, %s: failed with %0d errors", tests, name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	task automatic reset_values();
		int adr;
		for (adr = 0; adr < 32; adr++) begin
			if (adr != int'(reg_count)) begin
				read_check(adr[0], 5'(adr), $sformatf("register %0d after reset", adr));
			end
		end
	endtask

	task automatic random_rw();
		logic [31:0] val;
		logic        wr_dbg;
		int          i;
		for (i = 0; i < 4; i++) begin
			wr_dbg = i[0];
			val = next_random();
			bus_write(wr_dbg, reg_status, val);
			status_m = val & status_mask;
			read_check(~wr_dbg, reg_status, "status readback");
			val = next_random();
			bus_write(~wr_dbg, reg_epc, val);
			epc_m = val;
			read_check(wr_dbg, reg_epc, "epc readback");
			bus_write(wr_dbg, reg_cause, next_random()); // cause is read only.
			read_check(~wr_dbg, reg_cause, "cause after bus write");
		end
		bus_write(1'b0, reg_status, 32'h0);
		status_m = 32'h0;
	endtask

	task automatic contested_writes();
		logic [31:0] sdata;
		logic [31:0] edata;
		sdata = next_random();
		edata = next_random();
		fork
			bus_write(1'b0, reg_status, sdata);
			bus_write(1'b1, reg_epc, edata);
		join
		status_m = sdata & status_mask;
		epc_m = edata;
		read_check(1'b1, reg_status, "status after contested write");
		read_check(1'b0, reg_epc, "epc after contested write");
		bus_write(1'b0, reg_status, 32'h0);
		status_m = 32'h0;
	endtask

	task automatic exception_case(input logic bds);
		logic [31:0] tmp;
		logic [31:0] pc;
		logic [4:0]  code;
		tmp = next_random();
		code = (tmp[4:0] == 5'd0) ? 5'd8 : tmp[4:0];
		pc = next_random() & 32'hffff_fffc;
		@(negedge clk);
		exc = code;
		curr_pc = pc;
		in_bds = bds;
		#1;
		expect_value({31'b0, have2handle}, 32'd1, "have2handle on exception");
		@(negedge clk);
		enter_model(1'b0, code, pc, bds);
		#1;
		expect_value({31'b0, have2handle}, 32'd0, "have2handle while exl is set");
		expect_value(epc, epc_m, "epc output after entry");
		@(negedge clk);
		exc = 5'd0;
		curr_pc = 32'h0;
		in_bds = 1'b0;
		read_check(1'b0, reg_cause, "cause after exception");
		read_check(1'b1, reg_epc, "epc after exception");
		read_check(1'b0, reg_status, "status after exception");
		@(negedge clk);
		exit_isr = 1'b1; // leave the handler.
		@(negedge clk);
		exit_isr = 1'b0;
		status_m[sr_exl] = 1'b0;
		read_check(1'b1, reg_status, "status after exit_isr");
	endtask

	task automatic interrupt_case();
		logic [31:0] tmp;
		logic [31:0] pc;
		int          line;
		tmp = next_random();
		line = int'(tmp % 32'd5);
		pc = next_random() & 32'hffff_fffc;
		status_m = (32'h1 << (sr_im_lo + line)) | 32'h1; // mask bit and ie.
		bus_write(1'b0, reg_status, status_m);
		@(negedge clk);
		hwirq = 6'b1 << line;
		curr_pc = pc;
		#1;
		expect_value({31'b0, have2handle}, 32'd1, "have2handle on interrupt");
		@(negedge clk);
		enter_model(1'b1, 5'd0, pc, 1'b0);
		cause_m[cause_ip_hi:cause_ip_lo] = hwirq;
		#1;
		expect_value({31'b0, have2handle}, 32'd0, "have2handle during interrupt");
		read_check(1'b1, reg_cause, "cause on interrupt");
		read_check(1'b0, reg_epc, "epc on interrupt");
		@(negedge clk);
		hwirq = 6'b0;
		curr_pc = 32'h0;
		@(negedge clk);
		cause_m[cause_ip_hi:cause_ip_lo] = 6'b0;
		read_check(1'b0, reg_cause, "cause after hwirq drops");
		bus_write(1'b1, reg_status, 32'h0);
		status_m = 32'h0;
	endtask

	task automatic timer_case();
		logic [31:0] cnt;
		logic [31:0] val;
		logic        found;
		int          tries;
		found = 1'b0;
		tries = 0;
		bus_read(1'b0, reg_count, cnt);
		compare_m = cnt + 32'd20;
		bus_write(1'b1, reg_compare, compare_m);
		read_check(1'b0, reg_compare, "compare readback");
		while (!found && tries < 20) begin
			bus_read(1'b0, reg_cause, val);
			found = val[cause_ip_lo + 5];
			tries++;
		end
		expect_value({31'b0, found}, 32'd1, "timer pending in cause");
		compare_m = 32'h0;
		bus_write(1'b0, reg_compare, compare_m);
		@(negedge clk);
		read_check(1'b1, reg_cause, "cause after compare write");
	endtask

	initial begin
		seed = 32'd99699;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		status_m = 32'h0;
		cause_m = 32'h0;
		epc_m = 32'h0;
		compare_m = 32'h0;
		rst = 1'b1;
		drive_port(1'b0, 1'b0, 1'b0, 5'd0, 32'h0);
		drive_port(1'b1, 1'b0, 1'b0, 5'd0, 32'h0);
		exc = 5'd0;
		curr_pc = 32'h0;
		in_bds = 1'b0;
		exit_isr = 1'b0;
		hwirq = 6'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		reset_values();
		end_test("reset values");
		random_rw();
		end_test("random status and epc access");
		contested_writes();
		end_test("contested writes");
		exception_case(1'b0);
		exception_case(1'b1);
		end_test("exception entry and exit");
		interrupt_case();
		end_test("hardware interrupt");
		timer_case();
		end_test("timer interrupt");
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired, the tests did not finish in time");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
design/cp0_pkg.sv
design/cp0_wb_if.sv
design/cp0_wb_arbiter.sv
design/cp0_reg_decoder.sv
design/cp0_status.sv
design/cp0_timer.sv
design/cp0_top.sv
bench/cp0_assert.sv
bench/cp0_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the cp0 testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cp0_tb -f src.f -Mdir obj_dir -o cp0_sim &&
./obj_dir/cp0_sim | tee /dev/stderr | grep -qx "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
